/* rv_core.f */
logic/rv_pkg.sv
logic/rv_regfile.sv
logic/rv_decoder.sv
logic/rv_alu.sv
logic/rv_lsu.sv
logic/rv_memory.sv
logic/rv_core_top.sv
testbench/rv_core_assert.sv
testbench/tb_rv_core.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the rv_core testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module tb_rv_core \
  -f rv_core.f --Mdir obj_dir -o sim_tb > build.log 2>&1 \
  && ./obj_dir/sim_tb > sim.log 2>&1 \
  || echo "build or simulation returned an error, see build.log and sim.log"

cat sim.log 2>/dev/null

grep -qx "Everything OK" sim.log && echo "RESULT: PASS" && exit 0 \
  || { echo "RESULT: FAIL"; exit 1; }

/* testbench/program_input.hex */
// tag address word, all hex
// P is loaded through the host port in reset, E is expected after halt
// alu register forms, results at 0x200
P 00000000 20000513
P 00000004 30000593
P 00000008 ff900093
P 0000000c 00300113
P 00000010 402081b3
P 00000014 00352023
P 00000018 4020d233
P 0000001c 00452223
P 00000020 0020d2b3
P 00000024 00552423
P 00000028 0020a333
P 0000002c 00652623
P 00000030 0020b3b3
P 00000034 00752823
P 00000038 ffa0a413
P 0000003c fff13493
P 00000040 00852a23
P 00000044 00952c23
// lui, immediate and register logic and shifts, auipc
P 00000048 12345637
P 0000004c 67866613
P 00000050 fff64693
P 00000054 0f06f713
P 00000058 00461793
P 0000005c 4086d813
P 00000060 0086d893
P 00000064 00e78933
P 00000068 002619b3
P 0000006c 011842b3
P 00000070 00276333
P 00000074 010673b3
P 00000078 00001417
P 0000007c 00d52e23
P 00000080 02e52023
P 00000084 02f52223
P 00000088 03052423
P 0000008c 03152623
P 00000090 03252823
P 00000094 03352a23
P 00000098 02552c23
P 0000009c 02652e23
P 000000a0 04752023
P 000000a4 04852223
// loads from 0x300, each stored as a word at 0x280
P 000000a8 28000613
P 000000ac 00058083
P 000000b0 00162023
P 000000b4 00158083
P 000000b8 00162223
P 000000bc 00258083
P 000000c0 00162423
P 000000c4 00358083
P 000000c8 00162623
P 000000cc 0005c083
P 000000d0 00162823
P 000000d4 0015c083
P 000000d8 00162a23
P 000000dc 0025c083
P 000000e0 00162c23
P 000000e4 0035c083
P 000000e8 00162e23
P 000000ec 00059083
P 000000f0 02162023
P 000000f4 00259083
P 000000f8 02162223
P 000000fc 0005d083
P 00000100 02162423
P 00000104 0025d083
P 00000108 02162623
P 0000010c 0005a083
P 00000110 02162823
// sb and sh into cleared words
P 00000114 00d582a3
P 00000118 00d59323
P 0000011c 00d59423
P 00000120 006585a3
// branches, taken then not taken, x20 counts correct fallthroughs
P 00000124 00210463
P 00000128 100a0a13
P 0000012c 00228463
P 00000130 001a0a13
P 00000134 00229463
P 00000138 100a0a13
P 0000013c 00211463
P 00000140 001a0a13
P 00000144 0022c463
P 00000148 100a0a13
P 0000014c 00514463
P 00000150 001a0a13
P 00000154 00515463
P 00000158 100a0a13
P 0000015c 0022d463
P 00000160 001a0a13
P 00000164 00516463
P 00000168 100a0a13
P 0000016c 0022e463
P 00000170 001a0a13
P 00000174 0022f463
P 00000178 100a0a13
P 0000017c 00517463
P 00000180 001a0a13
P 00000184 05452423
// jal and jalr, link values stored
P 00000188 00c00aef
P 0000018c 100a0a13
P 00000190 100a0a13
P 00000194 05552623
P 00000198 1a900b13
P 0000019c 000b0be7
P 000001a0 100a0a13
P 000001a4 100a0a13
P 000001a8 05752823
P 000001ac 05452a23
// ecall, the store after it must not happen
P 000001b0 00000073
P 000001b4 04252c23
// data words
P 00000258 5a5a5a5a
P 00000300 7ff08081
P 00000304 00000000
P 00000308 00000000
P 0000030c c0ffee11
E 00000200 fffffff6
E 00000204 ffffffff
E 00000208 1fffffff
E 0000020c 00000001
E 00000210 00000000
E 00000214 00000001
E 00000218 00000001
E 0000021c edcba987
E 00000220 00000080
E 00000224 23456780
E 00000228 ffedcba9
E 0000022c 00edcba9
E 00000230 23456800
E 00000234 91a2b3c0
E 00000238 ff000000
E 0000023c 00000083
E 00000240 12244228
E 00000244 00001078
E 00000248 00000006
E 0000024c 0000018c
E 00000250 000001a0
E 00000254 00000006
E 00000258 5a5a5a5a
E 00000280 ffffff81
E 00000284 ffffff80
E 00000288 fffffff0
E 0000028c 0000007f
E 00000290 00000081
E 00000294 00000080
E 00000298 000000f0
E 0000029c 0000007f
E 000002a0 ffff8081
E 000002a4 00007ff0
E 000002a8 00008081
E 000002ac 00007ff0
E 000002b0 7ff08081
E 00000300 7ff08081
E 00000304 a9878700
E 00000308 8300a987
E 0000030c c0ffee11

/* testbench/tb_rv_core.sv */
`timescale 1ns/1ps

module tb_rv_core;
  import rv_pkg::*;

  logic  clk;
  logic  rst;
  logic  host_we;
  word_t host_addr;
  word_t host_wdata;
  word_t host_rdata;
  logic  halt;

  word_t prog_addr [$];
  word_t prog_data [$];
  word_t exp_addr [$];
  word_t exp_data [$];

  int errors;
  int checks;
  int timeouts;
  int assert_fails;
  int limit;

  rv_core_top #(
    .MEM_WORDS (1024)
  ) u_rv_core_top (
    .clk          (clk),
    .rst          (rst),
    .host_we_i    (host_we),
    .host_addr_i  (host_addr),
    .host_wdata_i (host_wdata),
    .host_rdata_o (host_rdata),
    .halt_o       (halt)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // P lines go to the program queues, E lines to the expected queues
  task automatic read_stimulus();
    int         fd;
    int         n;
    string      line;
    logic [7:0] tag;
    word_t      addr;
    word_t      data;
    fd = $fopen("testbench/program_input.hex", "r");
    if (fd == 0) begin
      $display("could not open testbench/program_input.hex");
      errors++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        n = $sscanf(line, "%c %h %h", tag, addr, data);
        if (n == 3 && tag == "P") begin
          prog_addr.push_back(addr);
          prog_data.push_back(data);
        end else if (n == 3 && tag == "E") begin
          exp_addr.push_back(addr);
          exp_data.push_back(data);
        end
      end
      $fclose(fd);
    end
  endtask

  // one host write per cycle, core held in reset
  task automatic load_program();
    for (int i = 0; i < prog_addr.size(); i++) begin
      @(posedge clk);
      host_we    <= 1'b1;
      host_addr  <= prog_addr[i];
      host_wdata <= prog_data[i];
    end
    @(posedge clk);
    host_we <= 1'b0;
  endtask

  task automatic wait_for_halt();
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (!halt && cycles < limit) begin
      @(negedge clk);
      cycles++;
    end
    if (!halt) begin
      $display("timeout: core did not halt within %0d cycles", limit);
      timeouts++;
    end
  endtask

  task automatic check_results();
    word_t got;
    for (int i = 0; i < exp_addr.size(); i++) begin
      @(posedge clk);
      host_addr <= exp_addr[i];
      @(negedge clk);
      got = host_rdata;
      checks++;
      assert (got === exp_data[i]) else begin
        $display("ERR %0t: addr %h expected %h got %h", $time, exp_addr[i], exp_data[i], got);
        errors++;
      end
    end
  endtask

  initial begin
    rst          = 1'b1;
    host_we      = 1'b0;
    host_addr    = '0;
    host_wdata   = '0;
    errors       = 0;
    checks       = 0;
    timeouts     = 0;
    assert_fails = 0;
    read_stimulus();
    limit = 16 * prog_addr.size() + 100;
    load_program();
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    wait_for_halt();
    if (timeouts == 0) begin
      check_results();
    end
    if (checks == 0 && timeouts == 0) begin
      $display("no expected values were checked");
      errors++;
    end
    assert_fails = u_rv_core_top.u_core_assert.fail_count;
    $display("checks %0d, errors %0d, assertion failures %0d, timeouts %0d",
             checks, errors, assert_fails, timeouts);
    if (errors == 0 && timeouts == 0 && assert_fails == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

/* testbench/rv_core_assert.sv */
`timescale 1ns/1ps

module rv_core_assert import rv_pkg::*; (
  input logic     clk,
  input logic     rst,
  input logic     halt_i,
  input logic     store_i,
  input word_t    pc_i,
  input byte_en_t be_i,
  input reg_idx_t rs1_idx_i,
  input reg_idx_t rs2_idx_i,
  input word_t    rs1_data_i,
  input word_t    rs2_data_i
);

  // number of assertion failures so far
  int fail_count = 0;

  pc_aligned: assert property (@(posedge clk) disable iff (rst) pc_i[1:0] == 2'b00)
    else begin
      $error("pc is not word aligned");
      fail_count++;
    end

  // x0 seen through either read port
  x0_rs1_zero: assert property (@(posedge clk) disable iff (rst)
    (rs1_idx_i == '0) |-> (rs1_data_i == '0))
    else begin
      $error("x0 read nonzero on rs1");
      fail_count++;
    end
  x0_rs2_zero: assert property (@(posedge clk) disable iff (rst)
    (rs2_idx_i == '0) |-> (rs2_data_i == '0))
    else begin
      $error("x0 read nonzero on rs2");
      fail_count++;
    end

  be_only_on_store: assert property (@(posedge clk)
    (be_i != '0) |-> (store_i && !halt_i && !rst))
    else begin
      $error("byte enables active without a live store");
      fail_count++;
    end

  pc_held_on_halt: assert property (@(posedge clk) disable iff (rst)
    halt_i |=> (pc_i == $past(pc_i)))
    else begin
      $error("pc moved while halted");
      fail_count++;
    end

endmodule

bind rv_core_top rv_core_assert u_core_assert (
  .clk        (clk),
  .rst        (rst),
  .halt_i     (halt_o),
  .store_i    (dec_store),
  .pc_i       (pc),
  .be_i       (data_be),
  .rs1_idx_i  (rs1_idx),
  .rs2_idx_i  (rs2_idx),
  .rs1_data_i (rs1_data),
  .rs2_data_i (rs2_data)
);

/* logic/rv_core_top.sv */
`timescale 1ns/1ps

module rv_core_top import rv_pkg::*; #(
  parameter int MEM_WORDS = 1024
) (
  input  logic  clk,
  input  logic  rst,
  input  logic  host_we_i,
  input  word_t host_addr_i,
  input  word_t host_wdata_i,
  output word_t host_rdata_o,
  output logic  halt_o
);

  word_t    pc, pc_next, pc_plus4, insn;
  reg_idx_t rs1_idx, rs2_idx, rd_idx;
  word_t    rs1_data, rs2_data, rd_data, dec_imm;
  alu_op_t  dec_alu_op;
  wb_sel_t  dec_wb_sel;
  funct3_t  dec_funct3;
  logic     dec_src_a_pc, dec_src_b_imm, dec_rd_we, dec_branch, dec_jal, dec_jalr;
  logic     dec_load, dec_store, dec_halt, rd_we, br_taken, core_active;
  word_t    alu_a, alu_b, alu_result;
  logic     alu_eq, alu_lt, alu_ltu;
  word_t    lsu_addr, data_addr, data_wdata, data_rdata, load_data;
  byte_en_t lsu_be, data_be;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= '0;
    end else begin
      pc <= pc_next;
    end
  end

  assign pc_plus4 = pc + 32'd4;
  assign halt_o   = dec_halt;

  // no architectural side effects while halted or in reset
  assign core_active = ~dec_halt & ~rst;
  assign rd_we       = dec_rd_we & core_active;
  assign data_be     = lsu_be & {4{core_active}};
  // data port parked at zero when no access is decoded
  assign data_addr   = (dec_load | dec_store) ? lsu_addr : '0;

  assign alu_a = dec_src_a_pc ? pc : rs1_data;
  assign alu_b = dec_src_b_imm ? dec_imm : rs2_data;

  always_comb begin
    case (dec_funct3)
      3'b000:  br_taken = alu_eq;
      3'b001:  br_taken = ~alu_eq;
      3'b100:  br_taken = alu_lt;
      3'b101:  br_taken = ~alu_lt;
      3'b110:  br_taken = alu_ltu;
      3'b111:  br_taken = ~alu_ltu;
      default: br_taken = 1'b0;
    endcase
  end

  always_comb begin
    if (dec_halt) begin
      pc_next = pc;
    end else if (dec_jalr) begin
      // jalr target is absolute, low bit cleared
      pc_next = {alu_result[XLEN-1:1], 1'b0};
    end else if (dec_jal || (dec_branch && br_taken)) begin
      pc_next = pc + dec_imm;
    end else begin
      pc_next = pc_plus4;
    end
  end

  always_comb begin
    case (dec_wb_sel)
      WB_LOAD:     rd_data = load_data;
      WB_PC_PLUS4: rd_data = pc_plus4;
      default:     rd_data = alu_result;
    endcase
  end

  rv_memory #(
    .MEM_WORDS (MEM_WORDS)
  ) u_memory (
    .clk          (clk),
    .fetch_addr_i (pc),
    .insn_o       (insn),
    .data_addr_i  (data_addr),
    .data_rdata_o (data_rdata),
    .data_wdata_i (data_wdata),
    .data_be_i    (data_be),
    .host_we_i    (host_we_i),
    .host_addr_i  (host_addr_i),
    .host_wdata_i (host_wdata_i),
    .host_rdata_o (host_rdata_o)
  );

  rv_decoder u_decoder (
    .insn_i      (insn),
    .rs1_idx_o   (rs1_idx),
    .rs2_idx_o   (rs2_idx),
    .rd_idx_o    (rd_idx),
    .imm_o       (dec_imm),
    .alu_op_o    (dec_alu_op),
    .src_a_pc_o  (dec_src_a_pc),
    .src_b_imm_o (dec_src_b_imm),
    .wb_sel_o    (dec_wb_sel),
    .rd_we_o     (dec_rd_we),
    .branch_o    (dec_branch),
    .jal_o       (dec_jal),
    .jalr_o      (dec_jalr),
    .load_o      (dec_load),
    .store_o     (dec_store),
    .funct3_o    (dec_funct3),
    .halt_o      (dec_halt)
  );

  rv_regfile u_regfile (
    .clk        (clk),
    .rst        (rst),
    .rs1_idx_i  (rs1_idx),
    .rs2_idx_i  (rs2_idx),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data),
    .rd_we_i    (rd_we),
    .rd_idx_i   (rd_idx),
    .rd_data_i  (rd_data)
  );

  rv_alu u_alu (
    .op_i     (dec_alu_op),
    .a_i      (alu_a),
    .b_i      (alu_b),
    .result_o (alu_result),
    .eq_o     (alu_eq),
    .lt_o     (alu_lt),
    .ltu_o    (alu_ltu)
  );

  rv_lsu u_lsu (
    .addr_i       (alu_result),
    .funct3_i     (dec_funct3),
    .store_i      (dec_store),
    .store_data_i (rs2_data),
    .mem_rdata_i  (data_rdata),
    .mem_addr_o   (lsu_addr),
    .mem_wdata_o  (data_wdata),
    .mem_be_o     (lsu_be),
    .load_data_o  (load_data)
  );

endmodule

/* logic/rv_memory.sv */
`timescale 1ns/1ps

module rv_memory import rv_pkg::*; #(
  parameter int MEM_WORDS = 1024
) (
  input  logic     clk,
  input  word_t    fetch_addr_i,
  output word_t    insn_o,
  input  word_t    data_addr_i,
  output word_t    data_rdata_o,
  input  word_t    data_wdata_i,
  input  byte_en_t data_be_i,
  input  logic     host_we_i,
  input  word_t    host_addr_i,
  input  word_t    host_wdata_i,
  output word_t    host_rdata_o
);

  localparam int AW = $clog2(MEM_WORDS);

  word_t         mem [MEM_WORDS];
  logic [AW-1:0] fetch_idx, data_idx, host_idx;

  // word index from the byte address
  assign fetch_idx = fetch_addr_i[AW+1:2];
  assign data_idx  = data_addr_i[AW+1:2];
  assign host_idx  = host_addr_i[AW+1:2];

  // reads are combinational, so a same-cycle store shows up next cycle
  assign insn_o       = mem[fetch_idx];
  assign data_rdata_o = mem[data_idx];
  assign host_rdata_o = mem[host_idx];

  always_ff @(posedge clk) begin
    if (host_we_i) begin
      mem[host_idx] <= host_wdata_i;
    end else begin
      for (int i = 0; i < 4; i++) begin
        if (data_be_i[i]) begin
          mem[data_idx][8*i +: 8] <= data_wdata_i[8*i +: 8];
        end
      end
    end
  end

endmodule

/* logic/rv_lsu.sv */
`timescale 1ns/1ps

module rv_lsu import rv_pkg::*; (
  input  word_t    addr_i,
  input  funct3_t  funct3_i,
  input  logic     store_i,
  input  word_t    store_data_i,
  input  word_t    mem_rdata_i,
  output word_t    mem_addr_o,
  output word_t    mem_wdata_o,
  output byte_en_t mem_be_o,
  output word_t    load_data_o
);

  word_t shifted;

  assign mem_addr_o = {addr_i[XLEN-1:2], 2'b00};

  // bring the addressed byte or halfword down to bit 0
  assign shifted = mem_rdata_i >> {addr_i[1:0], 3'b000};

  // store data is replicated so every lane carries it, enables pick the lane
  always_comb begin
    case (funct3_i[1:0])
      2'b00: begin
        mem_wdata_o = {4{store_data_i[7:0]}};
        mem_be_o    = byte_en_t'(4'b0001 << addr_i[1:0]);
      end
      2'b01: begin
        mem_wdata_o = {2{store_data_i[15:0]}};
        mem_be_o    = addr_i[1] ? 4'b1100 : 4'b0011;
      end
      default: begin
        mem_wdata_o = store_data_i;
        mem_be_o    = 4'b1111;
      end
    endcase
    if (!store_i) begin
      mem_be_o = '0;
    end
  end

  always_comb begin
    case (funct3_i)
      3'b000:  load_data_o = {{24{shifted[7]}}, shifted[7:0]};
      3'b001:  load_data_o = {{16{shifted[15]}}, shifted[15:0]};
      3'b100:  load_data_o = {24'b0, shifted[7:0]};
      3'b101:  load_data_o = {16'b0, shifted[15:0]};
      default: load_data_o = shifted;
    endcase
  end

endmodule

/* logic/rv_alu.sv */
`timescale 1ns/1ps

module rv_alu import rv_pkg::*; (
  input  alu_op_t op_i,
  input  word_t   a_i,
  input  word_t   b_i,
  output word_t   result_o,
  output logic    eq_o,
  output logic    lt_o,
  output logic    ltu_o
);

  logic [4:0] shamt;

  assign shamt = b_i[4:0];

  // branch compare flags, always valid
  assign eq_o  = (a_i == b_i);
  assign lt_o  = ($signed(a_i) < $signed(b_i));
  assign ltu_o = (a_i < b_i);

  always_comb begin
    case (op_i)
      ALU_ADD:    result_o = a_i + b_i;
      ALU_SUB:    result_o = a_i - b_i;
      ALU_SLL:    result_o = a_i << shamt;
      ALU_SLT:    result_o = {{(XLEN-1){1'b0}}, lt_o};
      ALU_SLTU:   result_o = {{(XLEN-1){1'b0}}, ltu_o};
      ALU_XOR:    result_o = a_i ^ b_i;
      ALU_SRL:    result_o = a_i >> shamt;
      ALU_SRA:    result_o = $signed(a_i) >>> shamt;
      ALU_OR:     result_o = a_i | b_i;
      ALU_AND:    result_o = a_i & b_i;
      ALU_PASS_B: result_o = b_i;
      default:    result_o = '0;
    endcase
  end

endmodule

/* logic/rv_decoder.sv */
`timescale 1ns/1ps

module rv_decoder import rv_pkg::*; (
  input  word_t    insn_i,
  output reg_idx_t rs1_idx_o,
  output reg_idx_t rs2_idx_o,
  output reg_idx_t rd_idx_o,
  output word_t    imm_o,
  output alu_op_t  alu_op_o,
  output logic     src_a_pc_o,
  output logic     src_b_imm_o,
  output wb_sel_t  wb_sel_o,
  output logic     rd_we_o,
  output logic     branch_o,
  output logic     jal_o,
  output logic     jalr_o,
  output logic     load_o,
  output logic     store_o,
  output funct3_t  funct3_o,
  output logic     halt_o
);

  opcode_t opcode;
  funct3_t funct3;
  logic    alt_op;
  word_t   imm_i, imm_s, imm_b, imm_u, imm_j;
  alu_op_t funct_op;

  assign opcode    = insn_i[6:0];
  assign funct3    = insn_i[14:12];
  // funct7 bit 5 selects sub and sra
  assign alt_op    = insn_i[30];
  assign rd_idx_o  = insn_i[11:7];
  assign rs1_idx_o = insn_i[19:15];
  assign rs2_idx_o = insn_i[24:20];
  assign funct3_o  = funct3;

  assign imm_i = {{20{insn_i[31]}}, insn_i[31:20]};
  assign imm_s = {{20{insn_i[31]}}, insn_i[31:25], insn_i[11:7]};
  assign imm_b = {{19{insn_i[31]}}, insn_i[31], insn_i[7], insn_i[30:25], insn_i[11:8], 1'b0};
  assign imm_u = {insn_i[31:12], 12'b0};
  assign imm_j = {{11{insn_i[31]}}, insn_i[31], insn_i[19:12], insn_i[20], insn_i[30:21], 1'b0};

  // funct3 to alu op for the op and op-imm groups
  always_comb begin
    case (funct3)
      3'b000:  funct_op = (opcode == OPC_OP && alt_op) ? ALU_SUB : ALU_ADD;
      3'b001:  funct_op = ALU_SLL;
      3'b010:  funct_op = ALU_SLT;
      3'b011:  funct_op = ALU_SLTU;
      3'b100:  funct_op = ALU_XOR;
      3'b101:  funct_op = alt_op ? ALU_SRA : ALU_SRL;
      3'b110:  funct_op = ALU_OR;
      default: funct_op = ALU_AND;
    endcase
  end

  always_comb begin
    imm_o       = '0;
    alu_op_o    = ALU_ADD;
    src_a_pc_o  = 1'b0;
    src_b_imm_o = 1'b1;
    wb_sel_o    = WB_ALU;
    rd_we_o     = 1'b0;
    branch_o    = 1'b0;
    jal_o       = 1'b0;
    jalr_o      = 1'b0;
    load_o      = 1'b0;
    store_o     = 1'b0;
    halt_o      = 1'b0;
    case (opcode)
      OPC_LUI: begin
        imm_o    = imm_u;
        alu_op_o = ALU_PASS_B;
        rd_we_o  = 1'b1;
      end
      OPC_AUIPC: begin
        imm_o      = imm_u;
        src_a_pc_o = 1'b1;
        rd_we_o    = 1'b1;
      end
      OPC_JAL: begin
        imm_o    = imm_j;
        wb_sel_o = WB_PC_PLUS4;
        rd_we_o  = 1'b1;
        jal_o    = 1'b1;
      end
      OPC_JALR: begin
        imm_o    = imm_i;
        wb_sel_o = WB_PC_PLUS4;
        rd_we_o  = 1'b1;
        jalr_o   = 1'b1;
      end
      OPC_BRANCH: begin
        // compare flags come from rs1 against rs2
        imm_o       = imm_b;
        src_b_imm_o = 1'b0;
        alu_op_o    = ALU_SUB;
        branch_o    = 1'b1;
      end
      OPC_LOAD: begin
        imm_o    = imm_i;
        wb_sel_o = WB_LOAD;
        rd_we_o  = 1'b1;
        load_o   = 1'b1;
      end
      OPC_STORE: begin
        imm_o   = imm_s;
        store_o = 1'b1;
      end
      OPC_OP_IMM: begin
        imm_o    = imm_i;
        alu_op_o = funct_op;
        rd_we_o  = 1'b1;
      end
      OPC_OP: begin
        src_b_imm_o = 1'b0;
        alu_op_o    = funct_op;
        rd_we_o     = 1'b1;
      end
      // ecall, fence and anything unknown stop the core
      default: halt_o = 1'b1;
    endcase
  end

endmodule

/* logic/rv_regfile.sv */
`timescale 1ns/1ps

module rv_regfile import rv_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  reg_idx_t rs1_idx_i,
  input  reg_idx_t rs2_idx_i,
  output word_t    rs1_data_o,
  output word_t    rs2_data_o,
  input  logic     rd_we_i,
  input  reg_idx_t rd_idx_i,
  input  word_t    rd_data_i
);

  word_t regs [32];

  // x0 is never written, so it keeps the value from reset
  assign rs1_data_o = regs[rs1_idx_i];
  assign rs2_data_o = regs[rs2_idx_i];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (rd_we_i && rd_idx_i != '0) begin
      regs[rd_idx_i] <= rd_data_i;
    end
  end

endmodule

/* logic/rv_pkg.sv */
package rv_pkg;

  localparam int XLEN = 32;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [4:0]      reg_idx_t;
  typedef logic [3:0]      byte_en_t;
  typedef logic [6:0]      opcode_t;
  typedef logic [2:0]      funct3_t;
  typedef logic [3:0]      alu_op_t;
  typedef logic [1:0]      wb_sel_t;

  // major opcodes, RV32I base
  localparam opcode_t OPC_LOAD     = 7'b0000011;
  localparam opcode_t OPC_MISC_MEM = 7'b0001111;
  localparam opcode_t OPC_OP_IMM   = 7'b0010011;
  localparam opcode_t OPC_AUIPC    = 7'b0010111;
  localparam opcode_t OPC_STORE    = 7'b0100011;
  localparam opcode_t OPC_OP       = 7'b0110011;
  localparam opcode_t OPC_LUI      = 7'b0110111;
  localparam opcode_t OPC_BRANCH   = 7'b1100011;
  localparam opcode_t OPC_JALR     = 7'b1100111;
  localparam opcode_t OPC_JAL      = 7'b1101111;
  localparam opcode_t OPC_SYSTEM   = 7'b1110011;

  // alu operations
  localparam alu_op_t ALU_ADD    = 4'd0;
  localparam alu_op_t ALU_SUB    = 4'd1;
  localparam alu_op_t ALU_SLL    = 4'd2;
  localparam alu_op_t ALU_SLT    = 4'd3;
  localparam alu_op_t ALU_SLTU   = 4'd4;
  localparam alu_op_t ALU_XOR    = 4'd5;
  localparam alu_op_t ALU_SRL    = 4'd6;
  localparam alu_op_t ALU_SRA    = 4'd7;
  localparam alu_op_t ALU_OR     = 4'd8;
  localparam alu_op_t ALU_AND    = 4'd9;
  // operand b straight through, for lui
  localparam alu_op_t ALU_PASS_B = 4'd10;

  // writeback sources
  localparam wb_sel_t WB_ALU      = 2'd0;
  localparam wb_sel_t WB_LOAD     = 2'd1;
  localparam wb_sel_t WB_PC_PLUS4 = 2'd2;

endpackage
